/* bench/tb_noc_router.sv */
module tb_noc_router;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period      = 8;
  localparam int router_x        = 1;
  localparam int router_y        = 1;
  localparam int num_pkts        = 30;               // Random packets per input.
  localparam int prio_flits      = 8;
  localparam int watchdog_factor = 40;
  localparam int num_keys        = noc_pkg::num_ports * noc_pkg::num_ports;

  logic               clk = 1'b0;
  logic               rst;
  noc_pkg::flit_t     rx_flit [noc_pkg::num_ports];
  noc_pkg::flit_t     tx_flit [noc_pkg::num_ports];
  noc_pkg::port_vec_t rx_rts;
  noc_pkg::port_vec_t rx_dcts;
  noc_pkg::port_vec_t tx_rts;
  noc_pkg::port_vec_t tx_dcts;

  noc_pkg::flit_t send_q [noc_pkg::num_ports][$];    // Flits the neighbors still offer.
  noc_pkg::flit_t pending_q [noc_pkg::num_ports][$];
  noc_pkg::flit_t exp_q [num_keys][$];               // Scoreboard per source and output.
  logic [6:0]     seq [noc_pkg::num_ports];
  int             open_src [noc_pkg::num_ports];
  int             order_q [$];
  int             errors [1:6];
  int             checks      = 0;
  int             total_flits = 0;
  int             recv_count  = 0;
  bit             prio_phase  = 1'b0;
  bit             reset_rts   = 1'b1;                // Neighbors request while in reset.

  always #(clk_period / 2) clk = ~clk;

  // Index order N, E, W, S, L as in the package.
  noc_router #(.x_pos(router_x), .y_pos(router_y)) noc_router_i (
    .clk, .rst,
    .rx_flit_n(rx_flit[0]), .rx_rts_n(rx_rts[0]), .rx_dcts_n(rx_dcts[0]),
    .tx_flit_n(tx_flit[0]), .tx_rts_n(tx_rts[0]), .tx_dcts_n(tx_dcts[0]),
    .rx_flit_e(rx_flit[1]), .rx_rts_e(rx_rts[1]), .rx_dcts_e(rx_dcts[1]),
    .tx_flit_e(tx_flit[1]), .tx_rts_e(tx_rts[1]), .tx_dcts_e(tx_dcts[1]),
    .rx_flit_w(rx_flit[2]), .rx_rts_w(rx_rts[2]), .rx_dcts_w(rx_dcts[2]),
    .tx_flit_w(tx_flit[2]), .tx_rts_w(tx_rts[2]), .tx_dcts_w(tx_dcts[2]),
    .rx_flit_s(rx_flit[3]), .rx_rts_s(rx_rts[3]), .rx_dcts_s(rx_dcts[3]),
    .tx_flit_s(tx_flit[3]), .tx_rts_s(tx_rts[3]), .tx_dcts_s(tx_dcts[3]),
    .rx_flit_l(rx_flit[4]), .rx_rts_l(rx_rts[4]), .rx_dcts_l(rx_dcts[4]),
    .tx_flit_l(tx_flit[4]), .tx_rts_l(tx_rts[4]), .tx_dcts_l(tx_dcts[4])
  );

  ////////////////////////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////////////////////////

  function automatic int route_port(input int dx, input int dy);
    if (dx > router_x) return noc_pkg::port_e;
    if (dx < router_x) return noc_pkg::port_w;
    if (dy < router_y) return noc_pkg::port_n;       // North is smaller y.
    if (dy > router_y) return noc_pkg::port_s;
    return noc_pkg::port_l;
  endfunction

  task automatic verify(input int test, input bit ok, input string msg);
    checks++;
    assert (ok) else begin
      errors[test]++;
      $display("Fail %0t: %s", $time, msg);
    end
  endtask

  task automatic report_test(input int test, input string name);
    if (errors[test] == 0) $display("Test %0d, %s: ok", test, name);
    else $display("Test %0d, %s: %0d errors", test, name, errors[test]);
  endtask

  // Body and tail flits carry their head's destination for the scoreboard.
  task automatic add_packet(input int src, input int len, input int dx, input int dy,
                            input bit later);
    noc_pkg::flit_t f;
    for (int i = 0; i < len; i++) begin
      if (len == 1) f.kind = noc_pkg::single;
      else if (i == 0) f.kind = noc_pkg::head;
      else if (i == len - 1) f.kind = noc_pkg::tail;
      else f.kind = noc_pkg::body;
      f.dst_x   = dx[noc_pkg::coord_bits-1:0];
      f.dst_y   = dy[noc_pkg::coord_bits-1:0];
      f.payload = {src[2:0], seq[src]};              // Source tag and sequence.
      seq[src]  = seq[src] + 7'd1;
      if (later) pending_q[src].push_back(f);
      else send_q[src].push_back(f);
    end
  endtask

  task automatic take_flit(input int o, input noc_pkg::flit_t f);
    int             src;
    noc_pkg::flit_t want;
    src = int'(f.payload[9:7]);
    recv_count++;
    verify(2, route_port(int'(f.dst_x), int'(f.dst_y)) == o,
           $sformatf("flit %h left on port %0d against XY routing", f, o));
    if (src >= noc_pkg::num_ports) begin
      verify(3, 1'b0, $sformatf("flit %h carries an unknown source tag", f));
      return;
    end
    if (exp_q[src * noc_pkg::num_ports + o].size() == 0) begin
      verify(3, 1'b0, $sformatf("port %0d sent an unexpected flit %h", o, f));
    end
    else begin
      want = exp_q[src * noc_pkg::num_ports + o].pop_front();
      verify(3, f == want, $sformatf("port %0d sent %h, expected %h", o, f, want));
    end
    if (f.kind == noc_pkg::head || f.kind == noc_pkg::single) begin
      verify(4, open_src[o] < 0, $sformatf("port %0d starts a packet inside another", o));
    end
    else begin
      verify(4, open_src[o] == src, $sformatf("port %0d mixes input %0d into a packet", o, src));
    end
    if (f.kind == noc_pkg::head) open_src[o] = src;
    if (f.kind == noc_pkg::tail || f.kind == noc_pkg::single) open_src[o] = -1;
    if (prio_phase && o == noc_pkg::port_e && f.kind == noc_pkg::head) order_q.push_back(src);
  endtask

  task automatic wait_delivered(input int count);
    while (recv_count < count) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // Neighbors, sinks and handshake monitor
  ////////////////////////////////////////////////////////////

  initial begin
    int                 wait_left [noc_pkg::num_ports];
    noc_pkg::flit_t     prev_flit [noc_pkg::num_ports];
    noc_pkg::port_vec_t prev_rts;
    noc_pkg::port_vec_t prev_dcts;
    noc_pkg::port_vec_t prev_rx_dcts;
    noc_pkg::flit_t     sent;
    rx_rts       = '0;
    tx_dcts      = '0;
    prev_rts     = '0;
    prev_dcts    = '0;
    prev_rx_dcts = '0;
    for (int p = 0; p < noc_pkg::num_ports; p++) begin
      rx_flit[p]   = '0;
      prev_flit[p] = '0;
      wait_left[p] = -1;
      open_src[p]  = -1;
    end
    forever begin
      @(negedge clk);
      for (int p = 0; p < noc_pkg::num_ports; p++) begin
        rx_rts[p] = reset_rts || send_q[p].size() != 0;
        if (send_q[p].size() != 0) rx_flit[p] = send_q[p][0];
        tx_dcts[p] = 1'b0;
        if (tx_rts[p] === 1'b1) begin
          if (wait_left[p] < 0) wait_left[p] = $urandom_range(3, 0);
          if (wait_left[p] == 0) begin
            tx_dcts[p]   = 1'b1;
            wait_left[p] = -1;
          end
          else begin
            wait_left[p]--;
          end
        end
      end
      #(clk_period / 2 - 1);                         // Just before the rising edge.
      for (int p = 0; p < noc_pkg::num_ports; p++) begin
        if (rx_rts[p] && rx_dcts[p] && send_q[p].size() != 0) begin
          sent = send_q[p].pop_front();
          exp_q[p * noc_pkg::num_ports + route_port(int'(sent.dst_x), int'(sent.dst_y))]
            .push_back(sent);
        end
        if (tx_rts[p] && tx_dcts[p]) take_flit(p, tx_flit[p]);
        if (!rst && prev_rts[p] && !prev_dcts[p]) begin
          verify(5, tx_rts[p] === 1'b1, $sformatf("port %0d dropped tx_rts unserved", p));
          verify(5, tx_flit[p] === prev_flit[p],
                 $sformatf("port %0d changed tx_flit while stalled", p));
        end
        if (!rst && prev_rts[p] && prev_dcts[p]) begin
          verify(5, tx_rts[p] === 1'b0, $sformatf("port %0d kept tx_rts after dcts", p));
        end
        if (!rst) begin
          verify(5, !(prev_rx_dcts[p] && rx_dcts[p]),
                 $sformatf("input %0d held rx_dcts for two cycles", p));
        end
      end
      if (!rst) begin
        prev_rts     = tx_rts;
        prev_dcts    = tx_dcts;
        prev_rx_dcts = rx_dcts;
        prev_flit    = tx_flit;
      end
    end
  end

  initial begin
    wait (total_flits != 0);
    #(watchdog_factor * total_flits * clk_period);
    $display("Timeout: traffic did not drain, %0d of %0d flits delivered", recv_count,
             total_flits);
    $display("test failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int len;
    int failed;
    int prio_order [4];
    void'($urandom(37262));
    rst        = 1'b1;
    prio_order = '{noc_pkg::port_l, noc_pkg::port_n, noc_pkg::port_s, noc_pkg::port_l};
    for (int t = 1; t <= 6; t++) errors[t] = 0;
    for (int p = 0; p < noc_pkg::num_ports; p++) seq[p] = '0;
    total_flits = prio_flits;
    for (int p = 0; p < noc_pkg::num_ports; p++) begin
      for (int k = 0; k < num_pkts; k++) begin
        len = $urandom_range(4, 1);
        add_packet(p, len, $urandom_range(3, 0), $urandom_range(3, 0), 1'b1);
        total_flits += len;
      end
    end

    // Every input requests during reset and must not be answered.
    @(negedge clk);
    for (int i = 0; i < 4; i++) begin
      #(clk_period / 2 - 1);
      verify(1, tx_rts === '0 && rx_dcts === '0, "handshake active during reset");
      if (i == 3) reset_rts = 1'b0;
      @(negedge clk);
    end
    rst = 1'b0;
    #(clk_period / 2 - 1);
    verify(1, tx_rts === '0 && rx_dcts === '0, "handshake active right after reset");
    report_test(1, "reset state");

    // L, N and S heads for east in one cycle, a second L packet behind the first.
    @(negedge clk);
    #1;
    prio_phase = 1'b1;
    add_packet(noc_pkg::port_l, 2, 3, router_y, 1'b0);
    add_packet(noc_pkg::port_n, 2, 3, router_y, 1'b0);
    add_packet(noc_pkg::port_s, 2, 3, router_y, 1'b0);
    add_packet(noc_pkg::port_l, 2, 3, router_y, 1'b0);
    wait_delivered(prio_flits);
    prio_phase = 1'b0;
    for (int i = 0; i < 4; i++) begin
      verify(6, order_q.size() > i && order_q[i] == prio_order[i],
             $sformatf("packet %0d on east came from the wrong input", i));
    end
    report_test(6, "arbiter priority");

    @(negedge clk);
    #1;
    for (int p = 0; p < noc_pkg::num_ports; p++) begin
      while (pending_q[p].size() != 0) send_q[p].push_back(pending_q[p].pop_front());
    end
    wait_delivered(total_flits);
    for (int k = 0; k < num_keys; k++) begin
      verify(3, exp_q[k].size() == 0, $sformatf("%0d flits from input %0d lost on port %0d",
             exp_q[k].size(), k / noc_pkg::num_ports, k % noc_pkg::num_ports));
    end
    report_test(2, "XY routing");
    report_test(3, "delivery");
    report_test(4, "packet contiguity");
    report_test(5, "handshake");

    failed = 0;
    for (int t = 1; t <= 6; t++) begin
      if (errors[t] != 0) failed++;
    end
    $display("Summary: 6 tests, %0d clean, %0d with errors, %0d checks, %0d flits",
             6 - failed, failed, checks, recv_count);
    if (failed == 0) begin
      $display("test passed");
    end
    else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* run.sh */
#!/bin/sh

top=tb_noc_router
build_dir=obj_dir
log=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module "$top" -Mdir "$build_dir" -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/V$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" "$log"; then
  exit 0
fi
echo "Pass message not found in $log"
exit 1

/* verilog.f */
verilog/noc_pkg.sv
verilog/port_link_if.sv
verilog/xy_route.sv
verilog/input_fifo.sv
verilog/output_port.sv
verilog/noc_router.sv
bench/tb_noc_router.sv

/* verilog/input_fifo.sv */
module input_fifo #(
  parameter int x_pos = 0,
  parameter int y_pos = 0
) (
  input  logic           clk,
  input  logic           rst,
  input  noc_pkg::flit_t rx_flit,
  input  logic           rx_rts,
  output logic           rx_dcts,
  port_link_if.source    link
);

  noc_pkg::flit_t             mem [noc_pkg::fifo_depth];
  logic [noc_pkg::ptr_bits:0] wr_ptr;                // Extra bit tells full from empty.
  logic [noc_pkg::ptr_bits:0] rd_ptr;
  logic                       empty;
  logic                       full;
  logic                       dcts_q;
  logic                       pop;
  noc_pkg::flit_t             head_flit;
  noc_pkg::port_vec_t         route;
  noc_pkg::port_vec_t         route_q;
  logic                       route_held;
  logic                       is_first;
  logic                       is_last;

  assign empty = wr_ptr == rd_ptr;
  assign full  = (wr_ptr ^ rd_ptr) == (noc_pkg::ptr_bits + 1)'(noc_pkg::fifo_depth);

  ////////////////////////////////////////////////////////////
  // Receive side
  ////////////////////////////////////////////////////////////

  assign rx_dcts = rx_rts & ~full & ~dcts_q & ~rst;  // One-cycle pulse, flit taken now.

  always_ff @(posedge clk) begin
    if (rst) begin
      dcts_q <= 1'b0;
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else begin
      dcts_q <= rx_dcts;
      if (rx_dcts) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rx_dcts) mem[wr_ptr[noc_pkg::ptr_bits-1:0]] <= rx_flit;
  end

  ////////////////////////////////////////////////////////////
  // Route latch
  ////////////////////////////////////////////////////////////

  assign head_flit = mem[rd_ptr[noc_pkg::ptr_bits-1:0]];
  assign is_first  = head_flit.kind == noc_pkg::head || head_flit.kind == noc_pkg::single;
  assign is_last   = head_flit.kind == noc_pkg::tail || head_flit.kind == noc_pkg::single;
  assign pop       = ~empty & (|link.grant);

  xy_route #(.x_pos(x_pos), .y_pos(y_pos)) route_i (
    .dst_x (head_flit.dst_x),
    .dst_y (head_flit.dst_y),
    .route (route)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      route_held <= 1'b0;
    end
    else if (pop && is_last) begin
      route_held <= 1'b0;                            // Packet closed.
    end
    else if (!route_held && !empty && is_first) begin
      route_held <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!route_held && !empty && is_first) route_q <= route;
  end

  assign link.flit  = head_flit;
  assign link.valid = ~empty;
  // Held through the whole packet so the output port stays with it.
  assign link.req   = route_held ? route_q : '0;

endmodule

/* verilog/noc_pkg.sv */
package noc_pkg;

  ////////////////////////////////////////////////////////////
  // Mesh and buffer sizes
  ////////////////////////////////////////////////////////////

  localparam int coord_bits = 2;
  localparam int flit_bits  = 16;
  localparam int fifo_depth = 4;                     // Power of two.
  localparam int ptr_bits   = $clog2(fifo_depth);
  localparam int num_ports  = 5;

  // Bit i of any port vector means port i.
  localparam int port_n = 0;
  localparam int port_e = 1;
  localparam int port_w = 2;
  localparam int port_s = 3;
  localparam int port_l = 4;

  ////////////////////////////////////////////////////////////
  // Flit format
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    head,
    body,
    tail,
    single
  } flit_kind_t;

  localparam int payload_bits = flit_bits - $bits(flit_kind_t) - 2 * coord_bits;

  typedef struct packed {
    flit_kind_t              kind;
    logic [coord_bits-1:0]   dst_x;                  // Head and single only.
    logic [coord_bits-1:0]   dst_y;
    logic [payload_bits-1:0] payload;
  } flit_t;

  typedef logic [num_ports-1:0] port_vec_t;

  // Output port FSM, bit 0 is idle and bit p+1 serves input p.
  localparam logic [num_ports:0] state_idle = (num_ports + 1)'(1);

endpackage

/* verilog/noc_router.sv */
module noc_router #(
  parameter int x_pos = 0,
  parameter int y_pos = 0
) (
  input  logic           clk,
  input  logic           rst,
  // North.
  input  noc_pkg::flit_t rx_flit_n,
  input  logic           rx_rts_n,
  output logic           rx_dcts_n,
  output noc_pkg::flit_t tx_flit_n,
  output logic           tx_rts_n,
  input  logic           tx_dcts_n,
  // East.
  input  noc_pkg::flit_t rx_flit_e,
  input  logic           rx_rts_e,
  output logic           rx_dcts_e,
  output noc_pkg::flit_t tx_flit_e,
  output logic           tx_rts_e,
  input  logic           tx_dcts_e,
  // West.
  input  noc_pkg::flit_t rx_flit_w,
  input  logic           rx_rts_w,
  output logic           rx_dcts_w,
  output noc_pkg::flit_t tx_flit_w,
  output logic           tx_rts_w,
  input  logic           tx_dcts_w,
  // South.
  input  noc_pkg::flit_t rx_flit_s,
  input  logic           rx_rts_s,
  output logic           rx_dcts_s,
  output noc_pkg::flit_t tx_flit_s,
  output logic           tx_rts_s,
  input  logic           tx_dcts_s,
  // Local.
  input  noc_pkg::flit_t rx_flit_l,
  input  logic           rx_rts_l,
  output logic           rx_dcts_l,
  output noc_pkg::flit_t tx_flit_l,
  output logic           tx_rts_l,
  input  logic           tx_dcts_l
);

  port_link_if #(.flit_type(noc_pkg::flit_t)) link [noc_pkg::num_ports] ();

  ////////////////////////////////////////////////////////////
  // Input stages
  ////////////////////////////////////////////////////////////

  input_fifo #(.x_pos(x_pos), .y_pos(y_pos)) in_n (
    .clk, .rst, .rx_flit(rx_flit_n), .rx_rts(rx_rts_n), .rx_dcts(rx_dcts_n),
    .link(link[noc_pkg::port_n])
  );
  input_fifo #(.x_pos(x_pos), .y_pos(y_pos)) in_e (
    .clk, .rst, .rx_flit(rx_flit_e), .rx_rts(rx_rts_e), .rx_dcts(rx_dcts_e),
    .link(link[noc_pkg::port_e])
  );
  input_fifo #(.x_pos(x_pos), .y_pos(y_pos)) in_w (
    .clk, .rst, .rx_flit(rx_flit_w), .rx_rts(rx_rts_w), .rx_dcts(rx_dcts_w),
    .link(link[noc_pkg::port_w])
  );
  input_fifo #(.x_pos(x_pos), .y_pos(y_pos)) in_s (
    .clk, .rst, .rx_flit(rx_flit_s), .rx_rts(rx_rts_s), .rx_dcts(rx_dcts_s),
    .link(link[noc_pkg::port_s])
  );
  input_fifo #(.x_pos(x_pos), .y_pos(y_pos)) in_l (
    .clk, .rst, .rx_flit(rx_flit_l), .rx_rts(rx_rts_l), .rx_dcts(rx_dcts_l),
    .link(link[noc_pkg::port_l])
  );

  ////////////////////////////////////////////////////////////
  // Output ports
  ////////////////////////////////////////////////////////////

  output_port #(.out_idx(noc_pkg::port_n)) out_n (
    .clk, .rst, .links(link), .tx_dcts(tx_dcts_n), .tx_flit(tx_flit_n), .tx_rts(tx_rts_n)
  );
  output_port #(.out_idx(noc_pkg::port_e)) out_e (
    .clk, .rst, .links(link), .tx_dcts(tx_dcts_e), .tx_flit(tx_flit_e), .tx_rts(tx_rts_e)
  );
  output_port #(.out_idx(noc_pkg::port_w)) out_w (
    .clk, .rst, .links(link), .tx_dcts(tx_dcts_w), .tx_flit(tx_flit_w), .tx_rts(tx_rts_w)
  );
  output_port #(.out_idx(noc_pkg::port_s)) out_s (
    .clk, .rst, .links(link), .tx_dcts(tx_dcts_s), .tx_flit(tx_flit_s), .tx_rts(tx_rts_s)
  );
  output_port #(.out_idx(noc_pkg::port_l)) out_l (
    .clk, .rst, .links(link), .tx_dcts(tx_dcts_l), .tx_flit(tx_flit_l), .tx_rts(tx_rts_l)
  );

endmodule

/* verilog/output_port.sv */
module output_port #(
  parameter int out_idx = 0
) (
  input  logic           clk,
  input  logic           rst,
  port_link_if.sink      links [noc_pkg::num_ports],
  input  logic           tx_dcts,
  output noc_pkg::flit_t tx_flit,
  output logic           tx_rts
);

  logic [noc_pkg::num_ports:0] state;                // One-hot, bit 0 is idle.
  logic [noc_pkg::num_ports:0] state_next;
  noc_pkg::port_vec_t          req;
  noc_pkg::port_vec_t          valids;
  noc_pkg::port_vec_t          serve;
  noc_pkg::port_vec_t          pick;
  noc_pkg::flit_t              flits [noc_pkg::num_ports];
  int                          start;
  logic                        serve_valid;
  logic                        rts_next;
  logic                        send;

  ////////////////////////////////////////////////////////////
  // Link access
  ////////////////////////////////////////////////////////////

  for (genvar p = 0; p < noc_pkg::num_ports; p++) begin : g_link
    assign req[p]                  = links[p].req[out_idx];
    assign valids[p]               = links[p].valid;
    assign flits[p]                = links[p].flit;
    assign links[p].grant[out_idx] = serve[p] & send;
  end

  assign serve       = state[noc_pkg::num_ports:1];
  assign serve_valid = |(serve & valids);
  assign send        = tx_rts & tx_dcts;             // Flit taken this cycle.

  ////////////////////////////////////////////////////////////
  // Arbiter
  ////////////////////////////////////////////////////////////

  // Idle uses the same list as serving L.
  always_comb begin
    start = noc_pkg::port_l;
    for (int p = 0; p < noc_pkg::num_ports; p++) begin
      if (serve[p]) start = p;
    end
  end

  // Rotated priority N, E, W, S, L starting at the served input.
  always_comb begin
    int idx;
    pick = '0;
    for (int k = 0; k < noc_pkg::num_ports; k++) begin
      idx = (start + k) % noc_pkg::num_ports;
      if (pick == '0 && req[idx]) pick[idx] = 1'b1;
    end
  end

  always_comb begin
    if (tx_rts && !tx_dcts) begin
      state_next = state;                            // Back-pressure.
    end
    else if (pick == '0) begin
      state_next = noc_pkg::state_idle;
    end
    else begin
      state_next = {pick, 1'b0};
    end
  end

  // Raise rts only on a settled state with a flit ready.
  always_comb begin
    rts_next = 1'b0;
    if (!state[0] && state_next == state && serve_valid && !send) begin
      rts_next = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= noc_pkg::state_idle;
      tx_rts <= 1'b0;
    end
    else begin
      state  <= state_next;
      tx_rts <= rts_next;
    end
  end

  ////////////////////////////////////////////////////////////
  // Crossbar column
  ////////////////////////////////////////////////////////////

  always_comb begin
    tx_flit = '0;
    for (int p = 0; p < noc_pkg::num_ports; p++) begin
      if (serve[p]) tx_flit = flits[p];
    end
  end

endmodule

/* verilog/port_link_if.sv */
interface port_link_if #(
  parameter type flit_type = noc_pkg::flit_t
);

  // One input stage towards all five output ports.
  flit_type           flit;                          // Flit at the FIFO head.
  logic               valid;                         // FIFO not empty.
  noc_pkg::port_vec_t req;                           // Route of the open packet.

  // Each output port drives only its own bit.
  wire noc_pkg::port_vec_t grant;

  modport source (
    output flit,
    output valid,
    output req,
    input  grant
  );

  modport sink (
    input  flit,
    input  valid,
    input  req,
    output grant
  );

endinterface

/* verilog/xy_route.sv */
module xy_route #(
  parameter int x_pos = 0,
  parameter int y_pos = 0
) (
  input  logic [noc_pkg::coord_bits-1:0] dst_x,
  input  logic [noc_pkg::coord_bits-1:0] dst_y,
  output noc_pkg::port_vec_t             route
);

  int dx;
  int dy;

  assign dx = int'(dst_x);
  assign dy = int'(dst_y);

  ////////////////////////////////////////////////////////////
  // Dimension order, X first
  ////////////////////////////////////////////////////////////

  always_comb begin
    route = '0;
    if (dx > x_pos) begin
      route[noc_pkg::port_e] = 1'b1;
    end
    else if (dx < x_pos) begin
      route[noc_pkg::port_w] = 1'b1;
    end
    else if (dy < y_pos) begin
      route[noc_pkg::port_n] = 1'b1;                 // North is decreasing y.
    end
    else if (dy > y_pos) begin
      route[noc_pkg::port_s] = 1'b1;
    end
    else begin
      route[noc_pkg::port_l] = 1'b1;                 // Arrived.
    end
  end

endmodule
